/* source/systolic_macros.svh */
`ifndef SYSTOLIC_MACROS_SVH
`define SYSTOLIC_MACROS_SVH

// Array geometry
`define SA_ROWS 5
`define SA_COLS 5

// Data and weights are signed bytes
`define SA_DATA_W 8

// Partial sums wrap at this width
`define SA_ACC_W 16

// Radix-4 digits needed for one data byte
`define SA_DIGITS 4

`endif

/* source/systolic_pkg.sv */
`include "systolic_macros.svh"

package systolic_pkg;

    // One radix-4 Booth digit, value in -2..+2
    typedef struct packed {
        logic neg;
        logic two;
        logic one;
    } booth_digit_t;

    // Digit k carries weight 4^k
    typedef booth_digit_t [`SA_DIGITS-1:0] booth_word_t;

    // Partial-product generator per digit
    typedef enum logic [1:0] {
        PP_EXACT     = 2'b00,
        PP_DROP_SIGN = 2'b01, // neg ignored
        PP_SINGLE    = 2'b10, // two treated as one
        PP_FORCE_NEG = 2'b11  // non-zero digits always negative
    } pp_mode_t;

    typedef pp_mode_t [`SA_DIGITS-1:0] pe_modes_t;

    typedef logic signed [`SA_DATA_W-1:0] data_t;
    typedef logic [`SA_ACC_W-1:0] acc_t;

    typedef data_t [`SA_ROWS-1:0] data_row_t;
    typedef data_t [`SA_COLS-1:0] weight_row_t;
    typedef acc_t [`SA_COLS-1:0] acc_row_t;

    // Indexed row*SA_COLS + column
    typedef pe_modes_t [`SA_ROWS*`SA_COLS-1:0] grid_modes_t;

endpackage

/* source/booth_row_encoder.sv */
`include "systolic_macros.svh"

module booth_row_encoder
    import systolic_pkg::*;
(
    input  data_t       data,
    output booth_word_t digits
);

    // Data with a zero below the LSB so every triplet overlaps by one bit
    logic [`SA_DATA_W:0] ext;

    assign ext = {data, 1'b0};

    always_comb begin
        for (int k = 0; k < `SA_DIGITS; k++) begin
            case (ext[2*k +: 3])
                3'b001, 3'b010: begin
                    digits[k].neg = 1'b0;
                    digits[k].two = 1'b0;
                    digits[k].one = 1'b1;
                end
                3'b011: begin // +2
                    digits[k].neg = 1'b0;
                    digits[k].two = 1'b1;
                    digits[k].one = 1'b0;
                end
                3'b100: begin // -2
                    digits[k].neg = 1'b1;
                    digits[k].two = 1'b1;
                    digits[k].one = 1'b0;
                end
                3'b101, 3'b110: begin
                    digits[k].neg = 1'b1;
                    digits[k].two = 1'b0;
                    digits[k].one = 1'b1;
                end
                default: begin // 000 and 111
                    digits[k].neg = 1'b0;
                    digits[k].two = 1'b0;
                    digits[k].one = 1'b0;
                end
            endcase
        end
    end

endmodule

/* source/booth_partial_product.sv */
`include "systolic_macros.svh"

module booth_partial_product
    import systolic_pkg::*;
(
    input  data_t                      weight,
    input  booth_digit_t               digit,
    input  pp_mode_t                   mode,
    output logic signed [`SA_ACC_W-1:0] pp
);

    logic signed [`SA_ACC_W-1:0] w1;
    logic signed [`SA_ACC_W-1:0] w2;
    logic signed [`SA_ACC_W-1:0] magnitude;
    logic                        use_two;
    logic                        negate;
    logic                        nonzero;

    // Sign-extended W and 2W
    assign w1 = weight;
    assign w2 = w1 <<< 1;

    assign nonzero = digit.one | digit.two;

    // Mode decides how the digit's sign and size are honoured
    always_comb begin
        case (mode)
            PP_DROP_SIGN: begin
                use_two = digit.two;
                negate  = 1'b0;
            end
            PP_SINGLE: begin
                use_two = 1'b0;
                negate  = digit.neg;
            end
            PP_FORCE_NEG: begin
                use_two = digit.two;
                negate  = 1'b1;
            end
            default: begin
                use_two = digit.two;
                negate  = digit.neg;
            end
        endcase
    end

    assign magnitude = use_two ? w2 : w1;

    always_comb begin
        if (!nonzero) begin
            pp = '0;
        end else if (negate) begin
            pp = -magnitude;
        end else begin
            pp = magnitude;
        end
    end

endmodule

/* source/booth_pe.sv */
`include "systolic_macros.svh"

module booth_pe
    import systolic_pkg::*;
#(
    parameter pe_modes_t modes = '{default: PP_EXACT}
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        load_weights,
    input  data_t       weight_in,
    output data_t       weight_out,
    input  booth_word_t digits_in,
    output booth_word_t digits_out,
    input  acc_t        acc_in,
    output acc_t        acc_out
);

    logic signed [`SA_ACC_W-1:0] pp [`SA_DIGITS];
    acc_t                        product;

    // weight_out doubles as the stationary weight
    for (genvar k = 0; k < `SA_DIGITS; k++) begin : g_pp
        booth_partial_product u_pp (
            .weight (weight_out),
            .digit  (digits_in[k]),
            .mode   (modes[k]),
            .pp     (pp[k])
        );
    end

    // Digit k sits 2k bits up; the sum wraps at the accumulator width
    always_comb begin
        product = '0;
        for (int k = 0; k < `SA_DIGITS; k++) begin
            product = product + acc_t'(pp[k] <<< (2*k));
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            weight_out <= '0;
        end else if (load_weights) begin
            weight_out <= weight_in; // Shift down one row per clock
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            digits_out <= '0;
            acc_out    <= '0;
        end else if (load_weights) begin
            // Flush the pipeline while weights move
            digits_out <= '0;
            acc_out    <= '0;
        end else begin
            digits_out <= digits_in;
            acc_out    <= acc_in + product;
        end
    end

endmodule

/* source/systolic_array.sv */
`include "systolic_macros.svh"

module systolic_array
    import systolic_pkg::*;
#(
    parameter grid_modes_t pe_modes = '{default: PP_EXACT}
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        load_weights,
    input  data_row_t   data_in,
    input  weight_row_t weight_in,
    output acc_row_t    acc_out
);

    // Digits run right, one extra slot past the last column
    booth_word_t digit_bus [`SA_ROWS][`SA_COLS+1];

    // Weights and sums run down, one extra slot below the last row
    data_t weight_bus [`SA_ROWS+1][`SA_COLS];
    acc_t  acc_bus    [`SA_ROWS+1][`SA_COLS];

    // Left edge, each row's data is encoded once
    for (genvar i = 0; i < `SA_ROWS; i++) begin : g_enc
        booth_row_encoder u_enc (
            .data   (data_in[i]),
            .digits (digit_bus[i][0])
        );
    end

    for (genvar j = 0; j < `SA_COLS; j++) begin : g_edge
        assign weight_bus[0][j] = weight_in[j];
        assign acc_bus[0][j]    = '0;            // Top row starts from zero
        assign acc_out[j]       = acc_bus[`SA_ROWS][j];
    end

    for (genvar i = 0; i < `SA_ROWS; i++) begin : g_row
        for (genvar j = 0; j < `SA_COLS; j++) begin : g_col
            booth_pe #(
                .modes (pe_modes[i*`SA_COLS + j])
            ) u_pe (
                .clk          (clk),
                .reset        (reset),
                .load_weights (load_weights),
                .weight_in    (weight_bus[i][j]),
                .weight_out   (weight_bus[i+1][j]),
                .digits_in    (digit_bus[i][j]),
                .digits_out   (digit_bus[i][j+1]),
                .acc_in       (acc_bus[i][j]),
                .acc_out      (acc_bus[i+1][j])
            );
        end
    end

endmodule

/* bench/systolic_model.svh */
`ifndef SYSTOLIC_MODEL_SVH
`define SYSTOLIC_MODEL_SVH

localparam int SCHED_LEN = CYC_LIMIT + 16;

// Stimulus and expected sums, indexed by clock edge
data_row_t           data_sched [SCHED_LEN];
weight_row_t         wt_sched   [SCHED_LEN];
logic                load_sched [SCHED_LEN];
acc_row_t            exp_acc    [SCHED_LEN];
logic [`SA_COLS-1:0] exp_en     [SCHED_LEN];

int model_w [`SA_ROWS][`SA_COLS]; // Weights the array should hold
int last_due = 0;                 // Latest edge with a pending check

// Armed at an edge, compared at the next one
acc_row_t            chk_exp = '0;
logic [`SA_COLS-1:0] chk_en  = '0;

function automatic grid_modes_t build_modes();
    grid_modes_t m;
    for (int n = 0; n < `SA_ROWS*`SA_COLS; n++) begin
        for (int k = 0; k < `SA_DIGITS; k++) begin
            m[n][k] = PP_EXACT;
        end
    end
    for (int k = 0; k < `SA_DIGITS; k++) begin
        m[4*`SA_COLS + 1][k] = PP_DROP_SIGN;
    end
    m[2*`SA_COLS + 3][0] = PP_SINGLE;
    m[2*`SA_COLS + 3][1] = PP_SINGLE;
    m[1*`SA_COLS + 4][3] = PP_FORCE_NEG;
    return m;
endfunction

localparam grid_modes_t TB_MODES = build_modes();

// Digit k is -2*b(2k+1) + b(2k) + b(2k-1), with b(-1) = 0
function automatic int booth_digit(data_t d, int k);
    logic [`SA_DATA_W:0] ext;
    int hi;
    int mid;
    int lo;
    ext = {d, 1'b0};
    hi  = ext[2*k+2];
    mid = ext[2*k+1];
    lo  = ext[2*k];
    return mid + lo - 2 * hi;
endfunction

function automatic int approx_pp(int d, int w, pp_mode_t mode);
    int mag;
    mag = (d < 0) ? -d : d;
    case (mode)
        PP_DROP_SIGN: return mag * w;
        PP_SINGLE:    return (d > 0) ? w : ((d < 0) ? -w : 0);
        PP_FORCE_NEG: return -mag * w;
        default:      return d * w;
    endcase
endfunction

function automatic acc_t cell_product(int i, int j, data_t d);
    int sum;
    sum = 0;
    for (int k = 0; k < `SA_DIGITS; k++) begin
        sum += approx_pp(booth_digit(d, k), model_w[i][j], TB_MODES[i*`SA_COLS + j][k]) * (4 ** k);
    end
    return acc_t'(sum); // Wraps like the hardware
endfunction

function automatic void clear_schedule();
    for (int e = 0; e < SCHED_LEN; e++) begin
        data_sched[e] = '0;
        wt_sched[e]   = '0;
        load_sched[e] = 1'b0;
        exp_acc[e]    = '0;
        exp_en[e]     = '0;
    end
endfunction

function automatic void expect_zero(int e);
    exp_acc[e] = '0;
    exp_en[e]  = '1;
    if (e > last_due) last_due = e;
endfunction

// Bottom row's weights enter first, then get pushed down by the rows above
function automatic void schedule_load(int l);
    for (int c = 0; c < `SA_ROWS; c++) begin
        load_sched[l+c] = 1'b1;
        for (int j = 0; j < `SA_COLS; j++) begin
            wt_sched[l+c][j] = data_t'(model_w[`SA_ROWS-1-c][j]);
        end
        expect_zero(l + c);
    end
endfunction

// Row i enters i edges after row 0; column j is due 4+j edges after the start
function automatic void schedule_wave(int t, data_row_t d);
    acc_row_t sums;
    sums = '0;
    for (int i = 0; i < `SA_ROWS; i++) begin
        data_sched[t+i][i] = d[i];
        for (int j = 0; j < `SA_COLS; j++) begin
            sums[j] = sums[j] + cell_product(i, j, d[i]);
        end
    end
    for (int j = 0; j < `SA_COLS; j++) begin
        exp_acc[t + `SA_ROWS - 1 + j][j] = sums[j];
        exp_en[t + `SA_ROWS - 1 + j][j]  = 1'b1;
    end
    if (t + `SA_ROWS + `SA_COLS - 2 > last_due) last_due = t + `SA_ROWS + `SA_COLS - 2;
endfunction

for (genvar j = 0; j < `SA_COLS; j++) begin : g_check
    column_sum: assert property (@(posedge clk) chk_en[j] |-> acc_out[j] == chk_exp[j])
    else begin
        fail_cnt++;
        $display("CHECK FAILED at time %0t: column %0d acc_out %0h, expected %0h",
                 $time, j, $sampled(acc_out[j]), $sampled(chk_exp[j]));
    end
end

`endif

/* bench/systolic_tb.sv */
`include "systolic_macros.svh"

module systolic_tb
    import systolic_pkg::*;
();

    // Cycle budget per test, reset included
    localparam int RESET_LEN   = 10;
    localparam int TEST_CYCLES = RESET_LEN + 6 + 18 + 14 + 18 + 30 + 44;
    localparam int CYC_LIMIT   = 2 * TEST_CYCLES;

    logic        clk;
    logic        reset;
    logic        load_weights;
    data_row_t   data_in;
    weight_row_t weight_in;
    acc_row_t    acc_out;

    int     cyc       = 0; // Rising edges seen so far
    int     check_cnt = 0;
    int     fail_cnt  = 0;
    int     test_checks0;
    int     test_fails0;
    integer seed      = 32'hc17a647c;

    `include "systolic_model.svh"

    systolic_array #(
        .pe_modes (TB_MODES)
    ) dut (
        .clk          (clk),
        .reset        (reset),
        .load_weights (load_weights),
        .data_in      (data_in),
        .weight_in    (weight_in),
        .acc_out      (acc_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Inputs for the next edge, checks for the state this edge leaves behind
    always @(posedge clk) begin
        data_in      <= data_sched[cyc+1];
        weight_in    <= wt_sched[cyc+1];
        load_weights <= load_sched[cyc+1];
        chk_exp      <= exp_acc[cyc];
        chk_en       <= exp_en[cyc];
        check_cnt    <= check_cnt + $countones(chk_en); // Compared at this edge
        cyc          <= cyc + 1;
        if (cyc >= CYC_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYC_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic data_t rand_byte();
        return data_t'($random(seed));
    endfunction

    function automatic data_row_t random_row();
        data_row_t r;
        for (int i = 0; i < `SA_ROWS; i++) begin
            r[i] = rand_byte();
        end
        return r;
    endfunction

    function automatic data_row_t fill_row(data_t v);
        data_row_t r;
        for (int i = 0; i < `SA_ROWS; i++) begin
            r[i] = v;
        end
        return r;
    endfunction

    function automatic void randomize_weights();
        for (int i = 0; i < `SA_ROWS; i++) begin
            for (int j = 0; j < `SA_COLS; j++) begin
                model_w[i][j] = rand_byte();
            end
        end
    endfunction

    task automatic wait_drain();
        while (cyc < last_due + 2) @(negedge clk);
    endtask

    task automatic mark_test_start();
        test_checks0 = check_cnt;
        test_fails0  = fail_cnt;
    endtask

    task automatic report_test(string name);
        wait_drain();
        $display("%s: %0d checks, %0d failed", name, check_cnt - test_checks0,
                 fail_cnt - test_fails0);
    endtask

    task automatic after_reset_zero();
        int now;
        mark_test_start();
        now = cyc;
        for (int e = now; e < now + 4; e++) begin
            expect_zero(e);
        end
        report_test("reset state");
    endtask

    task automatic load_clears_sums();
        int now;
        mark_test_start();
        randomize_weights();
        model_w[0][0] = -128;
        model_w[3][2] = 127;
        model_w[4][1] = -77; // Approximate cells need non-zero weights
        model_w[2][3] = 93;
        model_w[1][4] = -45;
        now = cyc;
        schedule_load(now + 1);
        // A wavefront is still in the grid when the same weights load again
        schedule_wave(now + 6, random_row());
        schedule_load(now + 10); // Its column sums are flushed to zero
        report_test("load clears sums");
    endtask

    task automatic exact_wavefronts();
        data_row_t lo_hi;
        data_row_t hi_lo;
        int        now;
        mark_test_start();
        now = cyc;
        for (int i = 0; i < `SA_ROWS; i++) begin
            lo_hi[i] = (i % 2 == 0) ? 8'h80 : 8'h7f;
            hi_lo[i] = (i % 2 == 0) ? 8'h7f : 8'h80;
        end
        schedule_wave(now + 1, lo_hi);
        schedule_wave(now + 2, hi_lo);
        schedule_wave(now + 3, random_row());
        report_test("exact wavefronts");
    endtask

    task automatic approx_cells();
        int now;
        mark_test_start();
        now = cyc;
        // 0x9a gives digits -2,-1,+2,-2 and 0x66 gives -2,+2,-2,+2
        schedule_wave(now + 1, fill_row(8'h9a));
        schedule_wave(now + 3, fill_row(8'h66));
        schedule_wave(now + 5, fill_row(8'h80));
        schedule_wave(now + 7, random_row());
        report_test("approximate cells");
    endtask

    task automatic back_to_back_waves();
        int now;
        mark_test_start();
        now = cyc;
        for (int n = 0; n < 20; n++) begin
            schedule_wave(now + 1 + n, random_row());
        end
        report_test("back-to-back wavefronts");
    endtask

    task automatic weights_persist();
        data_row_t batch [5];
        int        now;
        mark_test_start();
        now = cyc;
        for (int e = now; e < now + 6; e++) begin
            expect_zero(e); // Idle gap
        end
        for (int n = 0; n < 5; n++) begin
            batch[n] = random_row();
            schedule_wave(now + 7 + n, batch[n]);
        end
        wait_drain();
        randomize_weights();
        now = cyc;
        schedule_load(now + 1);
        for (int n = 0; n < 5; n++) begin
            schedule_wave(now + 6 + n, batch[n]); // Same data against new weights
        end
        report_test("weights persist and reload");
    endtask

    initial begin
        reset        = 1'b1;
        load_weights = 1'b0;
        data_in      = '0;
        weight_in    = '0;
        clear_schedule();
        repeat (RESET_LEN) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        after_reset_zero();
        load_clears_sums();
        exact_wavefronts();
        approx_cells();
        back_to_back_waves();
        weights_persist();
        $display("Checks passed %0d, failed %0d", check_cnt - fail_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+source
+incdir+bench
source/systolic_pkg.sv
source/booth_row_encoder.sv
source/booth_partial_product.sv
source/booth_pe.sv
source/systolic_array.sv
bench/systolic_tb.sv
